// File: dmac_pkg.sv
// Cluster DMA shared definitions
// Widths, config register offsets and the bus and job structs
`default_nettype none

package dmac_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 16;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [IdWidth-1:0]   id_t;

  // Config word offsets
  typedef enum logic [3:0] {
    REG_SRC        = 4'd0,
    REG_DST        = 4'd1,
    REG_LEN        = 4'd2,
    REG_SRC_STRIDE = 4'd3,
    REG_DST_STRIDE = 4'd4,
    REG_REPS       = 4'd5,
    REG_NEXT_ID    = 4'd6,
    REG_DONE_ID    = 4'd7,
    REG_STATUS     = 4'd8
  } reg_idx_e;

  // Full 2D transfer, length in words
  typedef struct packed {
    addr_t src;
    addr_t dst;
    data_t len;
    data_t src_stride;
    data_t dst_stride;
    data_t reps;
  } job_t;

  // One row handed to the backend
  typedef struct packed {
    addr_t src;
    addr_t dst;
    data_t len;
  } row_t;

  // Config bus, wen high means read
  typedef struct packed {
    logic       req;
    logic       wen;
    logic [3:0] offset;
    data_t      wdata;
  } cfg_req_t;

  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    data_t r_rdata;
  } cfg_rsp_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    data_t r_rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: dmac_cfg_port.sv
// Per-core DMA config register file
// Decodes register accesses and requests a launch on a NEXT_ID read
`timescale 1ns/1ps
`default_nettype none

module dmac_cfg_port (
  input  logic               clk_i,
  input  logic               reset_i,
  input  dmac_pkg::cfg_req_t cfg_i,
  output dmac_pkg::cfg_rsp_t cfg_o,
  output logic               launch_o,
  output dmac_pkg::job_t     job_o,
  input  logic               grant_i,
  input  dmac_pkg::id_t      issued_id_i,
  input  dmac_pkg::id_t      done_id_i,
  input  logic               busy_i
);

  dmac_pkg::job_t  job_q;
  dmac_pkg::data_t rdata;
  dmac_pkg::data_t r_rdata_q;
  logic            r_valid_q;
  logic            is_launch;
  logic            gnt;

  assign is_launch = cfg_i.req && cfg_i.wen && (cfg_i.offset == dmac_pkg::REG_NEXT_ID);
  assign launch_o  = is_launch;
  // Launch reads wait for the queue, all else is granted at once
  assign gnt       = cfg_i.req && (!is_launch || grant_i);

  always_comb begin
    case (cfg_i.offset)
      dmac_pkg::REG_SRC:        rdata = job_q.src;
      dmac_pkg::REG_DST:        rdata = job_q.dst;
      dmac_pkg::REG_LEN:        rdata = job_q.len;
      dmac_pkg::REG_SRC_STRIDE: rdata = job_q.src_stride;
      dmac_pkg::REG_DST_STRIDE: rdata = job_q.dst_stride;
      dmac_pkg::REG_REPS:       rdata = job_q.reps;
      dmac_pkg::REG_NEXT_ID:    rdata = dmac_pkg::data_t'(issued_id_i);
      dmac_pkg::REG_DONE_ID:    rdata = dmac_pkg::data_t'(done_id_i);
      dmac_pkg::REG_STATUS:     rdata = dmac_pkg::data_t'(busy_i);
      default:                  rdata = '0;
    endcase
  end

  // Job registers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      job_q <= '0;
    end else if (gnt && !cfg_i.wen) begin
      case (cfg_i.offset)
        dmac_pkg::REG_SRC:        job_q.src        <= cfg_i.wdata;
        dmac_pkg::REG_DST:        job_q.dst        <= cfg_i.wdata;
        dmac_pkg::REG_LEN:        job_q.len        <= cfg_i.wdata;
        dmac_pkg::REG_SRC_STRIDE: job_q.src_stride <= cfg_i.wdata;
        dmac_pkg::REG_DST_STRIDE: job_q.dst_stride <= cfg_i.wdata;
        dmac_pkg::REG_REPS:       job_q.reps       <= cfg_i.wdata;
        default: ;
      endcase
    end
  end

  // Response one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= gnt;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt) begin
      r_rdata_q <= cfg_i.wen ? rdata : '0;
    end
  end

  assign cfg_o.gnt     = gnt;
  assign cfg_o.r_valid = r_valid_q;
  assign cfg_o.r_rdata = r_rdata_q;
  assign job_o         = job_q;

  // Queue only grants a port that is asking
  assert property (@(posedge clk_i) disable iff (reset_i) grant_i |-> launch_o);

endmodule

`default_nettype wire

// File: dmac_job_queue.sv
// Shared DMA job queue
// Round-robin launch arbiter, ID assignment, job FIFO and done counter
`timescale 1ns/1ps
`default_nettype none

module dmac_job_queue #(
  parameter int unsigned NumPorts   = 4,
  parameter int unsigned QueueDepth = 4
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic           [NumPorts-1:0]       launch_i,
  input  dmac_pkg::job_t [NumPorts-1:0]       job_i,
  output logic           [NumPorts-1:0]       grant_o,
  output dmac_pkg::id_t                       issued_id_o,
  output dmac_pkg::job_t                      job_o,
  output logic                                job_valid_o,
  input  logic                                job_ready_i,
  input  logic                                job_done_i,
  output dmac_pkg::id_t                       done_id_o
);

  localparam int unsigned PortIdxWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;
  localparam int unsigned PtrWidth     = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntWidth     = $clog2(QueueDepth + 1);

  logic [PortIdxWidth-1:0] rr_q;
  logic [PortIdxWidth-1:0] winner;
  logic                    found;
  logic                    zero_job;
  logic                    accept;
  logic                    push;
  logic                    pop;
  logic                    full;
  dmac_pkg::id_t           id_q;
  dmac_pkg::id_t           done_id_q;

  dmac_pkg::job_t          fifo_q [QueueDepth];
  logic [PtrWidth-1:0]     wr_ptr_q;
  logic [PtrWidth-1:0]     rd_ptr_q;
  logic [CntWidth-1:0]     count_q;

  // ------------------------------------------------------------------------
  // Arbitration, search starts one past the last winner
  // ------------------------------------------------------------------------
  always_comb begin
    int unsigned idx;
    winner = '0;
    found  = 1'b0;
    for (int unsigned i = 1; i <= NumPorts; i++) begin
      idx = (int'(rr_q) + i) % NumPorts;
      if (!found && launch_i[idx]) begin
        found  = 1'b1;
        winner = idx[PortIdxWidth-1:0];
      end
    end
  end

  assign full     = (count_q == CntWidth'(QueueDepth));
  assign zero_job = (job_i[winner].len == '0) || (job_i[winner].reps == '0);
  assign accept   = found && !full;
  // Empty jobs get ID 0 and never reach the FIFO
  assign push     = accept && !zero_job;
  assign pop      = job_valid_o && job_ready_i;

  assign grant_o     = accept ? (NumPorts'(1) << winner) : '0;
  assign issued_id_o = zero_job ? '0 : id_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q      <= '0;
      id_q      <= dmac_pkg::id_t'(1);
      done_id_q <= '0;
    end else begin
      if (accept) begin
        rr_q <= winner;
      end
      if (push) begin
        id_q <= id_q + 1'b1;
      end
      if (job_done_i) begin
        done_id_q <= done_id_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Job FIFO
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= job_i[winner];
    end
  end

  assign job_o       = fifo_q[rd_ptr_q];
  assign job_valid_o = (count_q != '0);
  assign done_id_o   = done_id_q;

  // A push never takes the FIFO past its depth
  assert property (@(posedge clk_i) disable iff (reset_i)
    push |=> count_q <= CntWidth'(QueueDepth));

endmodule

`default_nettype wire

// File: dmac_2d_midend.sv
// DMA 2D midend
// Splits a queued job into strided rows and reports job completion
`timescale 1ns/1ps
`default_nettype none

module dmac_2d_midend (
  input  logic           clk_i,
  input  logic           reset_i,
  input  dmac_pkg::job_t job_i,
  input  logic           job_valid_i,
  output logic           job_ready_o,
  output dmac_pkg::row_t row_o,
  output logic           row_valid_o,
  input  logic           row_ready_i,
  input  logic           row_done_i,
  output logic           job_done_o,
  output logic           busy_o
);

  logic            active_q;
  logic            row_valid_q;
  logic            job_done_q;
  logic            take;
  logic            row_fire;
  dmac_pkg::row_t  row_q;
  dmac_pkg::data_t src_stride_q;
  dmac_pkg::data_t dst_stride_q;
  dmac_pkg::data_t reps_q;
  dmac_pkg::data_t rows_issued_q;
  dmac_pkg::data_t rows_done_q;

  assign job_ready_o = !active_q;
  assign take        = job_valid_i && job_ready_o;
  assign row_fire    = row_valid_q && row_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q      <= 1'b0;
      row_valid_q   <= 1'b0;
      job_done_q    <= 1'b0;
      rows_issued_q <= '0;
      rows_done_q   <= '0;
    end else begin
      job_done_q <= 1'b0;
      if (take) begin
        active_q      <= 1'b1;
        row_valid_q   <= 1'b1;
        rows_issued_q <= dmac_pkg::data_t'(1);
        rows_done_q   <= '0;
      end else begin
        // Last row handed over
        if (row_fire && rows_issued_q == reps_q) begin
          row_valid_q <= 1'b0;
        end else if (row_fire) begin
          rows_issued_q <= rows_issued_q + 1'b1;
        end
        if (row_done_i) begin
          rows_done_q <= rows_done_q + 1'b1;
          if (dmac_pkg::data_t'(rows_done_q + 1'b1) == reps_q) begin
            active_q   <= 1'b0;
            job_done_q <= 1'b1;
          end
        end
      end
    end
  end

  // Row addresses advance by one stride per accepted row
  always_ff @(posedge clk_i) begin
    if (take) begin
      row_q.src    <= job_i.src;
      row_q.dst    <= job_i.dst;
      row_q.len    <= job_i.len;
      src_stride_q <= job_i.src_stride;
      dst_stride_q <= job_i.dst_stride;
      reps_q       <= job_i.reps;
    end else if (row_fire) begin
      row_q.src <= row_q.src + src_stride_q;
      row_q.dst <= row_q.dst + dst_stride_q;
    end
  end

  assign row_o       = row_q;
  assign row_valid_o = row_valid_q;
  assign job_done_o  = job_done_q;
  assign busy_o      = active_q;

  assert property (@(posedge clk_i) disable iff (reset_i)
    row_valid_o && !row_ready_i |=> row_valid_o && $stable(row_o));

endmodule

`default_nettype wire

// File: dmac_copy_backend.sv
// DMA word-copy backend
// Reads and writes one row word by word over the TCDM and SoC ports
`timescale 1ns/1ps
`default_nettype none

module dmac_copy_backend #(
  parameter dmac_pkg::addr_t ClusterBaseAddr = 32'h1000_0000,
  parameter dmac_pkg::addr_t TcdmSize        = 32'h1_0000
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  dmac_pkg::row_t     row_i,
  input  logic               row_valid_i,
  output logic               row_ready_o,
  output logic               row_done_o,
  output logic               busy_o,
  output dmac_pkg::mem_req_t tcdm_o,
  input  dmac_pkg::mem_rsp_t tcdm_i,
  output dmac_pkg::mem_req_t soc_o,
  input  dmac_pkg::mem_rsp_t soc_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WAIT,
    ST_WRITE
  } state_e;

  state_e             state_q;
  dmac_pkg::row_t     row_q;
  dmac_pkg::data_t    data_q;
  logic               rd_tcdm_q;
  logic               row_done_q;

  dmac_pkg::addr_t    cur_addr;
  logic               cur_tcdm;
  logic               mem_gnt;
  logic               rd_valid;
  dmac_pkg::data_t    rd_data;
  dmac_pkg::mem_req_t acc;

  // ------------------------------------------------------------------------
  // Address map and port select
  // ------------------------------------------------------------------------
  assign cur_addr = (state_q == ST_WRITE) ? row_q.dst : row_q.src;
  assign cur_tcdm = (cur_addr >= ClusterBaseAddr) &&
                    ((cur_addr - ClusterBaseAddr) < TcdmSize);

  always_comb begin
    acc.req   = (state_q == ST_READ) || (state_q == ST_WRITE);
    acc.we    = (state_q == ST_WRITE);
    acc.addr  = cur_addr;
    acc.wdata = data_q;
    tcdm_o     = acc;
    tcdm_o.req = acc.req && cur_tcdm;
    soc_o      = acc;
    soc_o.req  = acc.req && !cur_tcdm;
  end

  assign mem_gnt  = cur_tcdm ? tcdm_i.gnt : soc_i.gnt;
  // Read data comes back on the port the read went to
  assign rd_valid = rd_tcdm_q ? tcdm_i.r_valid : soc_i.r_valid;
  assign rd_data  = rd_tcdm_q ? tcdm_i.r_rdata : soc_i.r_rdata;

  // ------------------------------------------------------------------------
  // Copy FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= ST_IDLE;
      row_done_q <= 1'b0;
    end else begin
      row_done_q <= 1'b0;
      case (state_q)
        ST_IDLE: if (row_valid_i) state_q <= ST_READ;
        ST_READ: if (mem_gnt) state_q <= ST_WAIT;
        ST_WAIT: if (rd_valid) state_q <= ST_WRITE;
        ST_WRITE: begin
          if (mem_gnt) begin
            if (row_q.len == dmac_pkg::data_t'(1)) begin
              state_q    <= ST_IDLE;
              row_done_q <= 1'b1;
            end else begin
              state_q <= ST_READ;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && row_valid_i) begin
      row_q <= row_i;
    end
    if (state_q == ST_READ && mem_gnt) begin
      rd_tcdm_q <= cur_tcdm;
    end
    if (state_q == ST_WAIT && rd_valid) begin
      data_q <= rd_data;
    end
    // Next word
    if (state_q == ST_WRITE && mem_gnt) begin
      row_q.src <= row_q.src + dmac_pkg::addr_t'(4);
      row_q.dst <= row_q.dst + dmac_pkg::addr_t'(4);
      row_q.len <= row_q.len - 1'b1;
    end
  end

  assign row_ready_o = (state_q == ST_IDLE);
  assign row_done_o  = row_done_q;
  assign busy_o      = (state_q != ST_IDLE);

  assert property (@(posedge clk_i) disable iff (reset_i)
    tcdm_o.req && !tcdm_i.gnt |=> tcdm_o.req && $stable(tcdm_o));
  assert property (@(posedge clk_i) disable iff (reset_i)
    soc_o.req && !soc_i.gnt |=> soc_o.req && $stable(soc_o));

endmodule

`default_nettype wire

// File: dmac_top.sv
// Cluster DMA controller top level
// Config ports, shared job queue, 2D midend and word-copy backend
`timescale 1ns/1ps
`default_nettype none

module dmac_top #(
  parameter int unsigned     NumPorts        = 4,
  parameter int unsigned     QueueDepth      = 4,
  parameter dmac_pkg::addr_t ClusterBaseAddr = 32'h1000_0000,
  parameter dmac_pkg::addr_t TcdmSize        = 32'h1_0000
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  dmac_pkg::cfg_req_t [NumPorts-1:0]  cfg_i,
  output dmac_pkg::cfg_rsp_t [NumPorts-1:0]  cfg_o,
  output dmac_pkg::mem_req_t                 tcdm_o,
  input  dmac_pkg::mem_rsp_t                 tcdm_i,
  output dmac_pkg::mem_req_t                 soc_o,
  input  dmac_pkg::mem_rsp_t                 soc_i,
  output logic               [NumPorts-1:0]  term_event_o,
  output logic                               busy_o
);

  logic           [NumPorts-1:0] launch;
  logic           [NumPorts-1:0] grant;
  dmac_pkg::job_t [NumPorts-1:0] port_job;
  dmac_pkg::id_t                 issued_id;
  dmac_pkg::id_t                 done_id;
  dmac_pkg::job_t                job;
  logic                          job_valid;
  logic                          job_ready;
  logic                          job_done;
  dmac_pkg::row_t                row;
  logic                          row_valid;
  logic                          row_ready;
  logic                          row_done;
  logic                          midend_busy;
  logic                          backend_busy;

  // ------------------------------------------------------------------------
  // Frontend
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < NumPorts; i++) begin : gen_cfg_ports
    dmac_cfg_port i_cfg_port (
      .clk_i       ( clk_i       ),
      .reset_i     ( reset_i     ),
      .cfg_i       ( cfg_i[i]    ),
      .cfg_o       ( cfg_o[i]    ),
      .launch_o    ( launch[i]   ),
      .job_o       ( port_job[i] ),
      .grant_i     ( grant[i]    ),
      .issued_id_i ( issued_id   ),
      .done_id_i   ( done_id     ),
      .busy_i      ( busy_o      )
    );
  end

  dmac_job_queue #(
    .NumPorts   ( NumPorts   ),
    .QueueDepth ( QueueDepth )
  ) i_job_queue (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .launch_i    ( launch    ),
    .job_i       ( port_job  ),
    .grant_o     ( grant     ),
    .issued_id_o ( issued_id ),
    .job_o       ( job       ),
    .job_valid_o ( job_valid ),
    .job_ready_i ( job_ready ),
    .job_done_i  ( job_done  ),
    .done_id_o   ( done_id   )
  );

  // ------------------------------------------------------------------------
  // Midend and backend
  // ------------------------------------------------------------------------
  dmac_2d_midend i_midend (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .job_i       ( job         ),
    .job_valid_i ( job_valid   ),
    .job_ready_o ( job_ready   ),
    .row_o       ( row         ),
    .row_valid_o ( row_valid   ),
    .row_ready_i ( row_ready   ),
    .row_done_i  ( row_done    ),
    .job_done_o  ( job_done    ),
    .busy_o      ( midend_busy )
  );

  dmac_copy_backend #(
    .ClusterBaseAddr ( ClusterBaseAddr ),
    .TcdmSize        ( TcdmSize        )
  ) i_backend (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .row_i       ( row          ),
    .row_valid_i ( row_valid    ),
    .row_ready_o ( row_ready    ),
    .row_done_o  ( row_done     ),
    .busy_o      ( backend_busy ),
    .tcdm_o      ( tcdm_o       ),
    .tcdm_i      ( tcdm_i       ),
    .soc_o       ( soc_o        ),
    .soc_i       ( soc_i        )
  );

  // Completion is broadcast to every core
  assign term_event_o = {NumPorts{job_done}};
  assign busy_o       = job_valid || midend_busy || backend_busy;

endmodule

`default_nettype wire

// File: tb_mem_model.sv
// Word memory model for one DMA memory port
// Grants after random stalls and returns read data one cycle after the grant
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
  parameter logic [31:0] Salt = 32'h0
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  dmac_pkg::mem_req_t req_i,
  output dmac_pkg::mem_rsp_t rsp_o
);

  dmac_pkg::data_t mem [dmac_pkg::addr_t];
  logic [31:0]     rng_q;
  logic            ready_q   = 1'b0;
  logic            r_valid_q = 1'b0;
  dmac_pkg::data_t r_rdata_q = '0;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Unwritten words hold a pattern of their full address
  function automatic dmac_pkg::data_t peek(input dmac_pkg::addr_t addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
  endfunction

  always @(posedge clk_i) begin
    if (reset_i) begin
      rng_q     <= 32'h2c8a ^ Salt;
      ready_q   <= 1'b0;
      r_valid_q <= 1'b0;
      r_rdata_q <= '0;
    end else begin
      rng_q     <= xorshift(rng_q);
      // Grant about three cycles in four
      ready_q   <= (rng_q[1:0] != 2'b00);
      r_valid_q <= req_i.req && ready_q && !req_i.we;
      if (req_i.req && ready_q) begin
        if (req_i.we) begin
          mem[req_i.addr] = req_i.wdata;
        end else begin
          r_rdata_q <= peek(req_i.addr);
        end
      end
    end
  end

  assign rsp_o.gnt     = req_i.req && ready_q;
  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_rdata = r_rdata_q;

endmodule

`default_nettype wire

// File: tb_dmac.sv
// Testbench for the cluster DMA controller
// Programs jobs over the config ports and checks memories, IDs and events
`timescale 1ns/1ps
`default_nettype none

module tb_dmac;

  localparam int unsigned     NumPorts    = 4;
  localparam int unsigned     QueueDepth  = 4;
  localparam dmac_pkg::addr_t ClusterBase = 32'h1000_0000;
  localparam dmac_pkg::addr_t TcdmSize    = 32'h1_0000;
  localparam int              Timeout     = 5000;

  logic                              clk;
  logic                              reset;
  logic                              reset_q;
  dmac_pkg::cfg_req_t [NumPorts-1:0] cfg;
  dmac_pkg::cfg_rsp_t [NumPorts-1:0] cfg_rsp;
  dmac_pkg::mem_req_t                tcdm_req;
  dmac_pkg::mem_rsp_t                tcdm_rsp;
  dmac_pkg::mem_req_t                soc_req;
  dmac_pkg::mem_rsp_t                soc_rsp;
  logic               [NumPorts-1:0] term_event;
  logic                              busy;
  logic                              any_active;
  logic                              soc_quiet;
  logic                              mem_quiet;

  int errors      = 0;
  int term_count  = 0;
  int outstanding = 0;
  int max_wait    = 0;
  dmac_pkg::data_t exp_mem [dmac_pkg::addr_t];

  initial clk = 1'b0;
  always #50 clk = ~clk;

  dmac_top #(
    .NumPorts        ( NumPorts    ),
    .QueueDepth      ( QueueDepth  ),
    .ClusterBaseAddr ( ClusterBase ),
    .TcdmSize        ( TcdmSize    )
  ) uut (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .cfg_i        ( cfg        ),
    .cfg_o        ( cfg_rsp    ),
    .tcdm_o       ( tcdm_req   ),
    .tcdm_i       ( tcdm_rsp   ),
    .soc_o        ( soc_req    ),
    .soc_i        ( soc_rsp    ),
    .term_event_o ( term_event ),
    .busy_o       ( busy       )
  );

  tb_mem_model #(.Salt(32'h0)) tcdm_mem (
    .clk_i(clk), .reset_i(reset), .req_i(tcdm_req), .rsp_o(tcdm_rsp)
  );
  tb_mem_model #(.Salt(32'h1357_0000)) soc_mem (
    .clk_i(clk), .reset_i(reset), .req_i(soc_req), .rsp_o(soc_rsp)
  );

  // TCDM window of the cluster address map
  function automatic logic in_tcdm(input dmac_pkg::addr_t a);
    return (a >= ClusterBase) && (a < ClusterBase + TcdmSize);
  endfunction

  function automatic dmac_pkg::data_t mem_peek(input dmac_pkg::addr_t a);
    return in_tcdm(a) ? tcdm_mem.peek(a) : soc_mem.peek(a);
  endfunction

  task automatic note_error(input string msg);
    errors++;
    $display("ERROR: %s at %0t", msg, $time);
  endtask

  always_comb begin
    any_active = tcdm_req.req || soc_req.req || busy || (term_event != '0);
    for (int i = 0; i < NumPorts; i++) begin
      any_active = any_active || cfg_rsp[i].gnt || cfg_rsp[i].r_valid;
    end
  end

  always @(posedge clk) begin
    reset_q = reset;
    if (!reset && term_event[0]) begin
      term_count++;
      outstanding--;
    end
  end

  // --------------------------------------------------------------------------
  // Protocol checks
  // --------------------------------------------------------------------------
  assert property (@(posedge clk) reset && reset_q |-> !any_active)
    else note_error("output active in reset");
  assert property (@(posedge clk) disable iff (reset) tcdm_req.req |-> in_tcdm(tcdm_req.addr))
    else note_error("SoC address on TCDM port");
  assert property (@(posedge clk) disable iff (reset) soc_req.req |-> !in_tcdm(soc_req.addr))
    else note_error("TCDM address on SoC port");
  assert property (@(posedge clk) disable iff (reset) soc_quiet |-> !soc_req.req)
    else note_error("unexpected SoC access");
  assert property (@(posedge clk) disable iff (reset)
    mem_quiet |-> !tcdm_req.req && !soc_req.req && term_event == '0)
    else note_error("activity for an empty job");
  assert property (@(posedge clk) disable iff (reset)
    term_event == '0 || term_event == {NumPorts{1'b1}})
    else note_error("completion not broadcast");
  assert property (@(posedge clk) disable iff (reset)
    outstanding != 0 && !term_event[0] |-> busy)
    else note_error("busy low with pending jobs");

  task automatic check_word(input string name, input dmac_pkg::data_t got,
                            input dmac_pkg::data_t exp);
    assert (got == exp) else begin
      errors++;
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // One config access, returns the response data
  task automatic cfg_access(input int port, input logic rd, input logic [3:0] off,
                            input dmac_pkg::data_t wdata, output dmac_pkg::data_t rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    cfg[port].req    = 1'b1;
    cfg[port].wen    = rd;
    cfg[port].offset = off;
    cfg[port].wdata  = wdata;
    @(negedge clk);
    while (!cfg_rsp[port].gnt && waited < Timeout) begin
      @(negedge clk);
      waited++;
    end
    if (waited > max_wait) begin
      max_wait = waited;
    end
    assert (cfg_rsp[port].gnt)
      else note_error($sformatf("timeout waiting for grant on port %0d", port));
    @(posedge clk);
    #1;
    cfg[port].req = 1'b0;
    @(negedge clk);
    assert (cfg_rsp[port].r_valid)
      else note_error($sformatf("no response on port %0d", port));
    rdata = cfg_rsp[port].r_rdata;
  endtask

  // Writes answer with zero data
  task automatic cfg_write(input int port, input logic [3:0] off, input dmac_pkg::data_t d);
    dmac_pkg::data_t rsp_data;
    cfg_access(port, 1'b0, off, d, rsp_data);
    check_word($sformatf("port%0d write r_rdata", port), rsp_data, 32'h0);
  endtask

  task automatic launch(input int port, output dmac_pkg::id_t id);
    dmac_pkg::data_t d;
    cfg_access(port, 1'b1, dmac_pkg::REG_NEXT_ID, '0, d);
    id = d[15:0];
    if (id != '0) begin
      outstanding++;
    end
  endtask

  function automatic dmac_pkg::job_t make_job(input dmac_pkg::addr_t src, dst,
      input dmac_pkg::data_t len, ss, ds, reps);
    dmac_pkg::job_t j;
    j.src = src;
    j.dst = dst;
    j.len = len;
    j.src_stride = ss;
    j.dst_stride = ds;
    j.reps = reps;
    return j;
  endfunction

  // Writes the job registers and applies the copy to the reference memory
  task automatic program_job(input int port, input dmac_pkg::job_t j);
    dmac_pkg::addr_t s;
    dmac_pkg::addr_t d;
    cfg_write(port, dmac_pkg::REG_SRC, j.src);
    cfg_write(port, dmac_pkg::REG_DST, j.dst);
    cfg_write(port, dmac_pkg::REG_LEN, j.len);
    cfg_write(port, dmac_pkg::REG_SRC_STRIDE, j.src_stride);
    cfg_write(port, dmac_pkg::REG_DST_STRIDE, j.dst_stride);
    cfg_write(port, dmac_pkg::REG_REPS, j.reps);
    for (int r = 0; r < int'(j.reps); r++) begin
      for (int w = 0; w < int'(j.len); w++) begin
        s = j.src + j.src_stride * r + 32'(4 * w);
        d = j.dst + j.dst_stride * r + 32'(4 * w);
        exp_mem[d] = mem_peek(s);
      end
    end
  endtask

  task automatic check_memories();
    foreach (exp_mem[a]) begin
      check_word($sformatf("mem[%h]", a), mem_peek(a), exp_mem[a]);
    end
  endtask

  task automatic wait_events(input int target);
    int waited;
    waited = 0;
    while (term_count < target && waited < Timeout * 4) begin
      @(negedge clk);
      waited++;
    end
    assert (term_count >= target)
      else note_error("timeout waiting for completion event");
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk);
    while (busy && waited < Timeout) begin
      @(negedge clk);
      waited++;
    end
    assert (!busy)
      else note_error("timeout waiting for busy to fall");
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial begin
    dmac_pkg::job_t  j;
    dmac_pkg::data_t rd;
    dmac_pkg::data_t val;
    dmac_pkg::id_t   id;
    dmac_pkg::id_t   id_a;
    dmac_pkg::id_t   id_b;
    int              base;

    reset     = 1'b1;
    cfg       = '0;
    soc_quiet = 1'b0;
    mem_quiet = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // Register readback on every port
    for (int p = 0; p < NumPorts; p++) begin
      for (int r = 0; r < 6; r++) begin
        val = 32'hc0de_0000 | dmac_pkg::data_t'(p << 8) | dmac_pkg::data_t'(r);
        cfg_write(p, 4'(r), val);
        cfg_access(p, 1'b1, 4'(r), '0, rd);
        check_word($sformatf("port%0d reg%0d", p, r), rd, val);
      end
      cfg_access(p, 1'b1, dmac_pkg::REG_STATUS, '0, rd);
      check_word("STATUS", rd, 32'h0);
    end

    // 1D copy inside the TCDM
    soc_quiet = 1'b1;
    j = make_job(32'h1000_0100, 32'h1000_0800, 32'd12, 32'h0, 32'h0, 32'd1);
    program_job(0, j);
    base = term_count;
    launch(0, id);
    check_word("issued id", 32'(id), 32'd1);
    wait_events(base + 1);
    wait_idle();
    soc_quiet = 1'b0;
    check_memories();
    cfg_access(0, 1'b1, dmac_pkg::REG_DONE_ID, '0, rd);
    check_word("DONE_ID", rd, 32'd1);

    // 2D copy from SoC to TCDM
    j = make_job(32'h8000_0000, 32'h1000_2000, 32'd6, 32'h40, 32'h80, 32'd4);
    program_job(1, j);
    launch(1, id);
    check_word("issued id", 32'(id), 32'd2);
    wait_events(base + 2);
    wait_idle();
    check_memories();

    // Empty jobs get ID 0 and never reach the memories
    mem_quiet = 1'b1;
    base = term_count;
    program_job(2, make_job(32'h1000_0000, 32'h1000_3000, 32'd0, 32'h0, 32'h0, 32'd3));
    launch(2, id);
    check_word("zero length id", 32'(id), 32'd0);
    program_job(3, make_job(32'h1000_0000, 32'h1000_3000, 32'd5, 32'h0, 32'h0, 32'd0));
    launch(3, id);
    check_word("zero reps id", 32'(id), 32'd0);
    repeat (10) @(negedge clk);
    check_word("event count", 32'(term_count), 32'(base));
    mem_quiet = 1'b0;

    // Two ports launching in the same cycle
    program_job(0, make_job(32'h1000_0400, 32'h8000_2000, 32'd4, 32'h0, 32'h0, 32'd1));
    program_job(1, make_job(32'h8000_3000, 32'h1000_5000, 32'd4, 32'h0, 32'h0, 32'd1));
    fork
      launch(0, id_a);
      launch(1, id_b);
    join
    assert ((id_a == 16'd3 && id_b == 16'd4) ||
            (id_a == 16'd4 && id_b == 16'd3)) else begin
      errors++;
      $display("MISMATCH t=%0t concurrent ids got %0d,%0d expected 3,4", $time, id_a, id_b);
    end

    // More jobs than the queue holds
    max_wait = 0;
    for (int k = 0; k < 8; k++) begin
      if (k % 2 == 0) begin
        j = make_job(32'h8000_8000 + 32'(k * 'h100), 32'h1000_6000 + 32'(k * 'h200),
                     32'd8, 32'h40, 32'h80, 32'd2);
      end else begin
        j = make_job(32'h1000_a000 + 32'(k * 'h100), 32'h9000_0000 + 32'(k * 'h200),
                     32'd8, 32'h40, 32'h80, 32'd2);
      end
      program_job(k % NumPorts, j);
      launch(k % NumPorts, id);
      check_word("queued id", 32'(id), 32'(k + 5));
    end
    assert (max_wait > 0)
      else note_error("full queue never held back a launch");
    wait_events(base + 10);
    wait_idle();
    check_word("outstanding", 32'(outstanding), 32'd0);
    check_memories();
    cfg_access(2, 1'b1, dmac_pkg::REG_DONE_ID, '0, rd);
    check_word("DONE_ID", rd, 32'd12);

    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
dmac_pkg.sv
dmac_cfg_port.sv
dmac_job_queue.sv
dmac_2d_midend.sv
dmac_copy_backend.sv
dmac_top.sv
tb_mem_model.sv
tb_dmac.sv

// File: run.sh
#!/bin/sh
# Build and run the DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_dmac -o sim_dmac \
  > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Build error, see build.log"
  exit 1
fi

./obj_dir/sim_dmac > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi

if ! grep -q "Test completed successfully" sim.log; then
  echo "No pass line found in sim.log"
  exit 1
fi

exit 0
